//--- common/cpuPkg.sv
package cpuPkg;

	typedef logic [31:0] wordT;      // Data word
	typedef logic [8:0] byteAddrT;   // 512-byte space
	typedef logic [4:0] regAddrT;    // Register number
	typedef logic [5:0] opcodeT;     // Primary opcode
	typedef logic [5:0] functT;      // R-type function

	// ALU selector from the control unit
	typedef enum logic [2:0] {
		aluFunct,   // Decode from funct
		aluAdd,
		aluSlt,
		aluSltu,
		aluAnd,
		aluOr,
		aluXor,
		aluLui
	} aluSelT;

	typedef enum logic {dstRt, dstRd} regDstT;     // Write-back register
	typedef enum logic {inAlu, inMem} regInT;      // Write-back source
	typedef enum logic {srcReg, srcImm} aluSrcT;   // ALU operand B

	// Instruction sequencer states
	typedef enum logic [3:0] {
		stFetch,       // MAR from PC
		stFetchWait,   // Hold read, load IR
		stDecode,
		stExecR,
		stExecImm,
		stMemAddr,     // Effective address to MAR
		stLoadWait,
		stLoadWrite,
		stStoreWait
	} cpuStateT;

	//////////////////////////////////////////////////
	// Opcodes
	localparam opcodeT opR     = 6'h00;
	localparam opcodeT opAddi  = 6'h08;
	localparam opcodeT opAddiu = 6'h09;
	localparam opcodeT opSlti  = 6'h0A;
	localparam opcodeT opSltiu = 6'h0B;
	localparam opcodeT opAndi  = 6'h0C;
	localparam opcodeT opOri   = 6'h0D;
	localparam opcodeT opXori  = 6'h0E;
	localparam opcodeT opLui   = 6'h0F;
	localparam opcodeT opLw    = 6'h23;
	localparam opcodeT opSw    = 6'h2B;

	//////////////////////////////////////////////////
	// R-type funct codes
	localparam functT fnSllv = 6'h04;
	localparam functT fnSrlv = 6'h06;
	localparam functT fnSrav = 6'h07;
	localparam functT fnAdd  = 6'h20;
	localparam functT fnAddu = 6'h21;
	localparam functT fnSub  = 6'h22;
	localparam functT fnSubu = 6'h23;
	localparam functT fnAnd  = 6'h24;
	localparam functT fnOr   = 6'h25;
	localparam functT fnXor  = 6'h26;
	localparam functT fnNor  = 6'h27;
	localparam functT fnSlt  = 6'h2A;
	localparam functT fnSltu = 6'h2B;

	localparam byteAddrT pcStep = 9'd4;   // One word
	localparam int regCount = 32;

endpackage

//--- common/ctrlIf.sv
`timescale 1ns/1ps

interface ctrlIf
	import cpuPkg::*;
();

	logic pcLd;       // PC plus pcStep
	logic irLd;       // Capture instruction
	logic marLd;
	logic marSel;     // 0 PC, 1 ALU result
	logic mdrLd;
	logic regWrite;
	regDstT regDst;
	regInT regIn;     // Also picks MDR source
	aluSrcT aluSrc;
	aluSelT aluSel;
	opcodeT opcode;   // Decode fields from IR
	functT funct;

	modport control (
		output pcLd, irLd, marLd, marSel, mdrLd, regWrite,
		output regDst, regIn, aluSrc, aluSel,
		input opcode, funct
	);

	modport datapath (
		input pcLd, irLd, marLd, marSel, mdrLd, regWrite,
		input regDst, regIn, aluSrc, aluSel,
		output opcode, funct
	);

endinterface

//--- hw/control/controlUnit.sv
`timescale 1ns/1ps

module controlUnit
	import cpuPkg::*;
(
	input  logic CLK,
	input  logic reset,
	input  logic memReady,   // Access completes this cycle
	output logic memRead,
	output logic memWrite,
	ctrlIf.control ctrl
);

	cpuStateT state;
	cpuStateT nextState;
	logic functKnown;   // Implemented R-type op
	aluSelT immSel;     // Selector for immediate ops

	//////////////////////////////////////////////////
	// State register and sequencing
	always_ff @(posedge CLK) begin
		if (reset) begin
			state <= stFetch;
		end else begin
			state <= nextState;
		end
	end

	always_comb begin
		nextState = state;
		case (state)
			stFetch: nextState = stFetchWait;
			stFetchWait: nextState = memReady ? stDecode : stFetchWait;
			stDecode: begin
				case (ctrl.opcode)
					opR: nextState = stExecR;
					opAddi, opAddiu, opSlti, opSltiu,
					opAndi, opOri, opXori, opLui: nextState = stExecImm;
					opLw, opSw: nextState = stMemAddr;
					default: nextState = stFetch;   // Unknown opcode acts as no-op
				endcase
			end
			stMemAddr: nextState = (ctrl.opcode == opLw) ? stLoadWait : stStoreWait;
			stLoadWait: nextState = memReady ? stLoadWrite : stLoadWait;
			stStoreWait: nextState = memReady ? stFetch : stStoreWait;
			default: nextState = stFetch;   // Exec and loadWrite end here
		endcase
	end

	//////////////////////////////////////////////////
	// Opcode and funct decode
	always_comb begin
		case (ctrl.opcode)
			opSlti: immSel = aluSlt;
			opSltiu: immSel = aluSltu;
			opAndi: immSel = aluAnd;
			opOri: immSel = aluOr;
			opXori: immSel = aluXor;
			opLui: immSel = aluLui;
			default: immSel = aluAdd;   // addi and addiu
		endcase
	end

	always_comb begin
		case (ctrl.funct)
			fnAdd, fnAddu, fnSub, fnSubu, fnAnd, fnOr, fnNor, fnXor,
			fnSlt, fnSltu, fnSllv, fnSrlv, fnSrav: functKnown = 1'b1;
			default: functKnown = 1'b0;   // Skip write-back
		endcase
	end

	//////////////////////////////////////////////////
	// Strobes and selects per state
	always_comb begin
		ctrl.pcLd = 1'b0;
		ctrl.irLd = 1'b0;
		ctrl.marLd = 1'b0;
		ctrl.marSel = 1'b0;
		ctrl.mdrLd = 1'b0;
		ctrl.regWrite = 1'b0;
		ctrl.regDst = dstRt;
		ctrl.regIn = inAlu;
		ctrl.aluSrc = srcReg;
		ctrl.aluSel = aluAdd;
		memRead = 1'b0;
		memWrite = 1'b0;
		case (state)
			stFetch: ctrl.marLd = 1'b1;   // MAR from PC
			stFetchWait: begin
				memRead = 1'b1;
				ctrl.irLd = memReady;
				ctrl.pcLd = memReady;
			end
			stExecR: begin
				ctrl.aluSel = aluFunct;
				ctrl.regDst = dstRd;
				ctrl.regWrite = functKnown;
			end
			stExecImm: begin
				ctrl.aluSrc = srcImm;
				ctrl.aluSel = immSel;
				ctrl.regWrite = 1'b1;
			end
			stMemAddr: begin
				ctrl.aluSrc = srcImm;   // rs plus offset
				ctrl.marSel = 1'b1;
				ctrl.marLd = 1'b1;
				ctrl.mdrLd = 1'b1;      // Store data from rt
			end
			stLoadWait: begin
				memRead = 1'b1;
				ctrl.regIn = inMem;     // MDR from memory
				ctrl.mdrLd = memReady;
			end
			stLoadWrite: begin
				ctrl.regIn = inMem;
				ctrl.regWrite = 1'b1;
			end
			stStoreWait: memWrite = 1'b1;
			default: ;   // Decode drives nothing
		endcase
	end

endmodule

//--- hw/datapath/registerFile.sv
`timescale 1ns/1ps

module registerFile
	import cpuPkg::*;
(
	input  logic CLK,
	input  logic reset,
	input  regAddrT rdAddrA,
	input  regAddrT rdAddrB,
	input  regAddrT wrAddr,
	input  wordT wrData,
	input  logic wrEn,
	output wordT rdDataA,
	output wordT rdDataB
);

	wordT regs [regCount];

	always_ff @(posedge CLK) begin
		if (reset) begin
			for (int i = 0; i < regCount; i++) begin
				regs[i] <= '0;
			end
		end else if (wrEn && (wrAddr != '0)) begin   // r0 stays zero
			regs[wrAddr] <= wrData;
		end
	end

	// Asynchronous read ports
	assign rdDataA = regs[rdAddrA];
	assign rdDataB = regs[rdAddrB];

endmodule

//--- hw/datapath/alu.sv
`timescale 1ns/1ps

module alu
	import cpuPkg::*;
(
	input  aluSelT aluSel,
	input  functT funct,
	input  wordT a,
	input  wordT b,
	output wordT result
);

	functT op;           // Resolved operation
	logic isLui;
	logic [4:0] shamt;   // Variable shift amount

	assign shamt = a[4:0];   // rs holds the amount

	// Selector to operation
	always_comb begin
		isLui = 1'b0;
		case (aluSel)
			aluFunct: op = funct;
			aluSlt: op = fnSlt;
			aluSltu: op = fnSltu;
			aluAnd: op = fnAnd;
			aluOr: op = fnOr;
			aluXor: op = fnXor;
			aluLui: begin
				op = fnAdd;
				isLui = 1'b1;
			end
			default: op = fnAdd;   // Address and addi
		endcase
	end

	always_comb begin
		if (isLui) begin
			result = {b[15:0], 16'h0000};
		end else begin
			case (op)
				fnAdd, fnAddu: result = a + b;   // Wraps
				fnSub, fnSubu: result = a - b;
				fnAnd: result = a & b;
				fnOr: result = a | b;
				fnNor: result = ~(a | b);
				fnXor: result = a ^ b;
				fnSlt: result = {31'b0, ($signed(a) < $signed(b))};
				fnSltu: result = {31'b0, (a < b)};
				fnSllv: result = b << shamt;
				fnSrlv: result = b >> shamt;
				fnSrav: result = $signed(b) >>> shamt;   // Sign fill
				default: result = '0;
			endcase
		end
	end

endmodule

//--- hw/datapath/datapath.sv
`timescale 1ns/1ps

module datapath
	import cpuPkg::*;
(
	input  logic CLK,
	input  logic reset,
	ctrlIf.datapath ctrl,
	input  wordT memRData,
	output byteAddrT memAddr,
	output wordT memWData,
	output wordT dataOut
);

	byteAddrT pc;
	byteAddrT mar;
	wordT ir;
	wordT mdr;
	wordT mdrIn;
	regAddrT rs;
	regAddrT rt;
	regAddrT rd;
	regAddrT wrAddr;
	logic [15:0] imm;
	logic zeroExt;     // Logical immediates
	wordT extImm;
	wordT regA;
	wordT regB;
	wordT aluB;
	wordT aluResult;
	wordT wrData;

	//////////////////////////////////////////////////
	// PC, IR, MAR and MDR
	always_ff @(posedge CLK) begin
		if (reset) begin
			pc <= '0;
			ir <= '0;
			mar <= '0;
			mdr <= '0;
		end else begin
			if (ctrl.pcLd) pc <= pc + pcStep;
			if (ctrl.irLd) ir <= memRData;
			if (ctrl.marLd) mar <= ctrl.marSel ? aluResult[8:0] : pc;   // Word aligned
			if (ctrl.mdrLd) mdr <= mdrIn;
		end
	end

	assign mdrIn = (ctrl.regIn == inMem) ? memRData : regB;   // Load data or rt

	// Instruction fields
	assign ctrl.opcode = ir[31:26];
	assign ctrl.funct = ir[5:0];
	assign rs = ir[25:21];
	assign rt = ir[20:16];
	assign rd = ir[15:11];
	assign imm = ir[15:0];

	//////////////////////////////////////////////////
	// Operand and write-back selection
	assign zeroExt = (ctrl.opcode == opAndi) || (ctrl.opcode == opOri) ||
		(ctrl.opcode == opXori);
	assign extImm = zeroExt ? {16'h0000, imm} : {{16{imm[15]}}, imm};
	assign aluB = (ctrl.aluSrc == srcImm) ? extImm : regB;
	assign wrAddr = (ctrl.regDst == dstRd) ? rd : rt;
	assign wrData = (ctrl.regIn == inMem) ? mdr : aluResult;

	registerFile regFile (
		.CLK(CLK),
		.reset(reset),
		.rdAddrA(rs),
		.rdAddrB(rt),
		.wrAddr(wrAddr),
		.wrData(wrData),
		.wrEn(ctrl.regWrite),
		.rdDataA(regA),
		.rdDataB(regB)
	);

	alu aluUnit (
		.aluSel(ctrl.aluSel),
		.funct(ctrl.funct),
		.a(regA),
		.b(aluB),
		.result(aluResult)
	);

	assign memAddr = mar;
	assign memWData = mdr;
	assign dataOut = aluResult;   // Live ALU result

endmodule

//--- hw/mipsProcessor.sv
`timescale 1ns/1ps

module mipsProcessor
	import cpuPkg::*;
(
	input  logic CLK,
	input  logic reset,
	input  logic memReady,     // Access done
	input  wordT memRData,
	output byteAddrT memAddr,
	output wordT memWData,
	output logic memRead,      // Held until memReady
	output logic memWrite,
	output wordT dataOut       // Current ALU result
);

	ctrlIf ctrl ();

	controlUnit cu (
		.CLK(CLK),
		.reset(reset),
		.memReady(memReady),
		.memRead(memRead),
		.memWrite(memWrite),
		.ctrl(ctrl.control)
	);

	datapath dp (
		.CLK(CLK),
		.reset(reset),
		.ctrl(ctrl.datapath),
		.memRData(memRData),
		.memAddr(memAddr),
		.memWData(memWData),
		.dataOut(dataOut)
	);

endmodule

//--- test/tbProgram.svh
// Program image, word N sits at byte address 4*N
localparam int progLen = 43;
localparam int storeCount = 21;

wordT progTable [progLen] = '{
	32'h2001FFFB, 32'hAC010100,                 // addi r1,r0,-5; sw r1,0x100
	32'h28220003, 32'h2C230003,                 // slti r2,r1,3; sltiu r3,r1,3
	32'hAC020104, 32'hAC030108,                 // sw r2,0x104; sw r3,0x108
	32'h34048F0F, 32'h3025F0F0, 32'h38268001,   // ori r4,r0,0x8F0F; andi r5; xori r6
	32'hAC04010C, 32'hAC050110, 32'hAC060114,   // sw r4 r5 r6
	32'h3C078000, 32'h24E8FFFF,                 // lui r7,0x8000; addiu r8,r7,-1
	32'hAC070118, 32'hAC08011C,                 // sw r7 r8
	32'h01024820, 32'h00025022,                 // add r9,r8,r2; sub r10,r0,r2
	32'hAC090120, 32'hAC0A0124,                 // sw r9 r10
	32'h00855824, 32'h00856025,                 // and r11,r4,r5; or r12,r4,r5
	32'h00856827, 32'h00867026,                 // nor r13,r4,r5; xor r14,r4,r6
	32'hAC0B0128, 32'hAC0C012C, 32'hAC0D0130, 32'hAC0E0134,   // sw r11 to r14
	32'h0022782A, 32'h0022802B,                 // slt r15,r1,r2; sltu r16,r1,r2
	32'hAC0F0138, 32'hAC10013C,                 // sw r15 r16
	32'h20110004,                               // addi r17,r0,4
	32'h02269004, 32'h02269806, 32'h0226A007,   // sllv srlv srav of r6 by r17
	32'hAC120140, 32'hAC130144, 32'hAC140148,   // sw r18 r19 r20
	32'h8C150110, 32'hAC15014C,                 // lw r21,0x110; sw r21,0x14C
	32'h20001234, 32'hAC000150                  // addi r0,r0,0x1234; sw r0,0x150
};

// Store address in bits 40:32, store data below
logic [40:0] storeTable [storeCount] = '{
	{9'h100, 32'hFFFFFFFB}, {9'h104, 32'h00000001}, {9'h108, 32'h00000000},
	{9'h10C, 32'h00008F0F}, {9'h110, 32'h0000F0F0}, {9'h114, 32'hFFFF7FFA},
	{9'h118, 32'h80000000}, {9'h11C, 32'h7FFFFFFF}, {9'h120, 32'h80000000},
	{9'h124, 32'hFFFFFFFF}, {9'h128, 32'h00008000}, {9'h12C, 32'h0000FFFF},
	{9'h130, 32'hFFFF0000}, {9'h134, 32'hFFFFF0F5}, {9'h138, 32'h00000001},
	{9'h13C, 32'h00000000}, {9'h140, 32'hFFF7FFA0}, {9'h144, 32'h0FFFF7FF},
	{9'h148, 32'hFFFFF7FF}, {9'h14C, 32'h0000F0F0}, {9'h150, 32'h00000000}
};

//--- test/mipsProcessorTb.sv
`timescale 1ns/1ps

module mipsProcessorTb
	import cpuPkg::*;
();

	localparam int waitLimit = 20;   // Cycles per wait
	localparam int memWords = 128;

	`include "tbProgram.svh"

	logic CLK;
	logic reset;
	logic memReady;
	wordT memRData;
	byteAddrT memAddr;
	wordT memWData;
	logic memRead;
	logic memWrite;
	wordT dataOut;

	wordT mem [memWords];   // Word-wide memory model
	logic [15:0] lfsr;
	byteAddrT expPc;        // Own copy of the PC
	int storeIdx;
	logic dataNext;         // Next read belongs to an lw

	mipsProcessor UUT (
		.CLK(CLK),
		.reset(reset),
		.memReady(memReady),
		.memRData(memRData),
		.memAddr(memAddr),
		.memWData(memWData),
		.memRead(memRead),
		.memWrite(memWrite),
		.dataOut(dataOut)
	);

	initial begin
		CLK = 1'b0;
		forever #2 CLK = ~CLK;
	end

	//////////////////////////////////////////////////
	// Helpers
	task automatic failRun(string why);
		$display("%s", why);
		$display("Test FAILED");
		$fatal(1);
	endtask

	task automatic checkValue(string name, wordT got, wordT exp);
		if (got !== exp) begin
			failRun($sformatf("error %s got %h expected %h", name, got, exp));
		end
	endtask

	function automatic logic [15:0] nextLfsr(logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);   // Taps 16 14 13 11
	endfunction

	task automatic loadMemory();
		for (int i = 0; i < memWords; i++) begin
			// Unknown opcode in unused words, low bits carry the address
			mem[i] = (i < progLen) ? progTable[i] : (32'hFC000000 | (i * 4));
		end
	endtask

	task automatic waitRequest();
		int cycles;
		cycles = 0;
		while (!(memRead || memWrite)) begin
			if (cycles == waitLimit) failRun("no memory request within timeout");
			@(negedge CLK);
			cycles++;
		end
	endtask

	//////////////////////////////////////////////////
	// One access, random hold-off then a single memReady cycle
	task automatic serveRequest();
		logic [1:0] delay;
		logic isWrite;
		logic storeNext;
		byteAddrT addr;
		wordT word;
		delay = '0;
		storeNext = 1'b0;
		isWrite = memWrite;
		addr = memAddr;
		for (int i = 0; i < 2; i++) begin
			delay = {delay[0], lfsr[0]};   // One step per bit
			lfsr = nextLfsr(lfsr);
		end
		repeat (delay) begin
			@(negedge CLK);
			checkValue("memAddr", memAddr, addr);   // Held stable
			if (isWrite) begin
				checkValue("memWrite", memWrite, 1);
			end else begin
				checkValue("memRead", memRead, 1);
			end
		end
		word = mem[addr[8:2]];
		if (isWrite) begin
			if (storeIdx >= storeCount) failRun("store outside the expected-store table");
			checkValue("memAddr", addr, storeTable[storeIdx][40:32]);
			checkValue("memWData", memWData, storeTable[storeIdx][31:0]);
			mem[addr[8:2]] = memWData;
			storeIdx++;
		end else if (dataNext) begin
			memRData = word;   // lw data
			dataNext = 1'b0;
		end else begin
			if (expPc >= progLen * 4) failRun("fetch past the end of the program");
			checkValue("fetch memAddr", addr, expPc);
			memRData = word;
			dataNext = (word[31:26] == opLw);
			storeNext = (word[31:26] == opSw);
			expPc = expPc + 9'd4;
		end
		memReady = 1'b1;
		@(negedge CLK);
		memReady = 1'b0;
		if (storeNext) begin
			// Effective address on the ALU one cycle after decode
			@(negedge CLK);
			checkValue("dataOut", dataOut, {23'b0, storeTable[storeIdx][40:32]});
		end
	endtask

	//////////////////////////////////////////////////
	// Main loop
	initial begin
		reset = 1'b1;
		memReady = 1'b0;
		memRData = '0;
		lfsr = 16'd12075;
		expPc = '0;
		storeIdx = 0;
		dataNext = 1'b0;
		loadMemory();
		repeat (5) begin
			@(negedge CLK);
			checkValue("memRead", memRead, 0);   // Quiet under reset
			checkValue("memWrite", memWrite, 0);
		end
		reset = 1'b0;
		@(negedge CLK);
		checkValue("memRead", memRead, 1);   // First fetch one cycle later
		checkValue("memAddr", memAddr, 0);
		while (storeIdx < storeCount) begin
			waitRequest();
			serveRequest();
		end
		$display("Test OK");
		$finish;
	end

endmodule

//--- list.f
+incdir+test
common/cpuPkg.sv
common/ctrlIf.sv
hw/control/controlUnit.sv
hw/datapath/registerFile.sv
hw/datapath/alu.sv
hw/datapath/datapath.sv
hw/mipsProcessor.sv
test/mipsProcessorTb.sv

//--- Bender.yml
package:
  name: mips_processor

sources:
  - common/cpuPkg.sv
  - common/ctrlIf.sv
  - hw/control/controlUnit.sv
  - hw/datapath/registerFile.sv
  - hw/datapath/alu.sv
  - hw/datapath/datapath.sv
  - hw/mipsProcessor.sv
  - target: test
    include_dirs:
      - test
    files:
      - test/mipsProcessorTb.sv
